// File: vlog.f
+incdir+common
common/lsu_pkg.sv
common/bus_pkg.sv
common/dmem_if.sv
lsu/load_align.sv
lsu/lsu_core.sv
hdl/dmem_sram.sv
hdl/mmio_regs.sv
hdl/lsu_top.sv
testbench/tb_lsu_top.sv

// File: Makefile
# Verilator build and run for the LSU subsystem testbench

VERILATOR ?= verilator
TOP       ?= tb_lsu_top
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --timescale 1ns/1ps -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, search the log for a pass"
	@echo "  clean  remove the build directory and the log"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -qx "RESULT: PASS" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: testbench/tb_lsu_top.sv
/*
 * Testbench for the LSU subsystem
 * Directed tests against shadow models of data memory and MMIO scratch registers
 */
`default_nettype none

`include "lsu_cfg.svh"

module tb_lsu_top;
    timeunit 1ns;
    timeprecision 1ps;

    import lsu_pkg::*;
    import bus_pkg::*;

    logic       g_clk = 1'b0;
    logic       g_resetn;
    logic       lsu_valid;
    lsu_op_e    lsu_op;
    lsu_width_e lsu_width;
    logic       lsu_signed;
    word_t      lsu_addr;
    word_t      lsu_wdata;
    logic       pipe_prog;
    logic       hold_lsu_req;
    logic       ext_hold;
    logic       lsu_ready;
    logic       lsu_a_error;
    logic       lsu_mmio;
    word_t      lsu_rdata;

    logic [7:0] shadow_mem [4*`DMEM_WORDS];     // Byte image of data memory
    word_t      shadow_scr [4];                 // Scratch register image
    word_t      got_rdata;                      // Captured in the ready cycle
    logic       got_err;
    logic       got_mmio;
    int         got_lat;                        // Cycles until ready
    logic       rand_hold = 1'b0;               // Random stalls on/off
    int         n_access  = 0;
    int         n_checks  = 0;
    int         n_errors  = 0;
    int         cycle_cnt = 0;

    lsu_top i_lsu_top (.*);

    always #5 g_clk = ~g_clk;                   // 10 ns period

    // Run limit grows with the accesses issued
    always @(posedge g_clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt > 40 * (n_access + 1) + 20) begin
            $display("Timeout: run stalled after %0d cycles and %0d accesses",
                     cycle_cnt, n_access);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    // Compare tasks ------------------------------
    task automatic check_word(input string what, input word_t got, input word_t want);
        n_checks++;
        if (got !== want) begin
            n_errors++;
            $display("ERROR %0t: %s got %08h expected %08h", $time, what, got, want);
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic want);
        n_checks++;
        if (got !== want) begin
            n_errors++;
            $display("ERROR %0t: %s got %b expected %b", $time, what, got, want);
        end
    endtask

    // Reference model ------------------------------
    function automatic int byte_index(input word_t addr);
        return int'(addr & word_t'(4*`DMEM_WORDS - 1));   // Memory wraps
    endfunction

    function automatic word_t expect_load(input word_t addr, input lsu_width_e w,
                                          input logic sgn);
        int          a;
        logic [15:0] h;
        a = byte_index(addr);
        h = {shadow_mem[a+1 < 4*`DMEM_WORDS ? a+1 : 0], shadow_mem[a]};
        case (w)
            width_byte: return {{24{sgn & h[7]}}, h[7:0]};
            width_half: return {{16{sgn & h[15]}}, h};
            default:    return {shadow_mem[a+3], shadow_mem[a+2], h};
        endcase
    endfunction

    function automatic word_t rand_addr(input lsu_width_e w);
        word_t r;
        r = $urandom() & word_t'(4*`DMEM_WORDS - 1);   // Below MMIO window
        if (w == width_half) r[0] = 1'b0;
        if (w == width_word) r[1:0] = 2'b00;
        return r;
    endfunction

    task automatic randomize_holds;
        word_t r;
        r = $urandom();
        hold_lsu_req = r[0];
        ext_hold     = r[1] & r[2];             // Other master on 1 in 4
    endtask

    // One instruction, presented until ready, then retired
    task automatic run_access(input lsu_op_e op, input lsu_width_e w, input logic sgn,
                              input word_t addr, input word_t wdata, input int retire_wait);
        logic done;
        n_access++;
        lsu_valid  = 1'b1;
        lsu_op     = op;
        lsu_width  = w;
        lsu_signed = sgn;
        lsu_addr   = addr;
        lsu_wdata  = wdata;
        if (rand_hold) randomize_holds();
        got_lat = 0;
        done    = 1'b0;
        while (!done) begin
            @(negedge g_clk);                   // Outputs settled here
            got_lat++;
            if (lsu_ready) begin
                done      = 1'b1;
                got_rdata = lsu_rdata;
                got_err   = lsu_a_error;
                got_mmio  = lsu_mmio;
            end else begin
                @(posedge g_clk);
                #1;
                if (rand_hold) randomize_holds();
            end
        end
        for (int k = 0; k < retire_wait; k++) begin
            @(posedge g_clk);
            #1;
            @(negedge g_clk);
            check_flag("ready held until retire", lsu_ready, 1'b1);
        end
        @(posedge g_clk);
        #1;
        pipe_prog    = 1'b1;
        hold_lsu_req = 1'b0;
        ext_hold     = 1'b0;
        @(posedge g_clk);
        #1;
        pipe_prog = 1'b0;
        lsu_valid = 1'b0;
    endtask

    task automatic store_mem(input lsu_width_e w, input word_t addr, input word_t data,
                             input int retire_wait);
        int a;
        int nb;
        run_access(op_store, w, 1'b0, addr, data, retire_wait);
        check_flag("store error flag", got_err, 1'b0);
        check_flag("store mmio flag", got_mmio, 1'b0);
        a  = byte_index(addr);
        nb = (w == width_byte) ? 1 : (w == width_half) ? 2 : 4;
        for (int i = 0; i < nb; i++) begin
            shadow_mem[a+i] = data[8*i +: 8];   // Low bytes land at addr
        end
    endtask

    task automatic load_mem(input lsu_width_e w, input logic sgn, input word_t addr,
                            input int retire_wait);
        run_access(op_load, w, sgn, addr, '0, retire_wait);
        check_flag("load error flag", got_err, 1'b0);
        check_flag("load mmio flag", got_mmio, 1'b0);
        check_word("load data", got_rdata, expect_load(addr, w, sgn));
    endtask

    // Tests ------------------------------
    task automatic init_memory;
        for (int i = 0; i < `DMEM_WORDS; i++) begin
            store_mem(width_word, word_t'(4*i), $urandom(), 0);
        end
    endtask

    task automatic test_word_rw;
        word_t a;
        for (int i = 0; i < 16; i++) begin
            a = rand_addr(width_word);
            store_mem(width_word, a, $urandom(), 0);
            check_flag("store takes one cycle", got_lat == 1, 1'b1);
            load_mem(width_word, 1'b0, a, 0);
            check_flag("load takes two cycles", got_lat == 2, 1'b1);
        end
    endtask

    task automatic test_sub_word;
        word_t a;
        a = rand_addr(width_word);
        for (int l = 0; l < 4; l++) begin
            store_mem(width_byte, a + l, $urandom(), 0);
            load_mem(width_word, 1'b0, a, 0);   // Only one lane changed
        end
        for (int l = 0; l < 4; l += 2) begin
            store_mem(width_half, a + l, $urandom(), 0);
            load_mem(width_word, 1'b0, a, 0);
        end
        store_mem(width_word, a, 32'h80F0_7F81, 0);   // Both sign polarities
        for (int s = 0; s < 2; s++) begin
            for (int l = 0; l < 4; l++) begin
                load_mem(width_byte, s[0], a + l, 0);
            end
            load_mem(width_half, s[0], a, 0);
            load_mem(width_half, s[0], a + 2, 0);
        end
    endtask

    task automatic test_misaligned;
        word_t a;
        a = rand_addr(width_word);
        for (int off = 1; off < 4; off++) begin
            for (int k = 0; k < 4; k++) begin
                if (off[0] || k[0]) begin       // Half needs odd offset, word any
                    run_access(k[1] ? op_store : op_load,
                               k[0] ? width_word : width_half, 1'b0, a + off, $urandom(), 0);
                    check_flag("misaligned error flag", got_err, 1'b1);
                    check_flag("misaligned ready in first cycle", got_lat == 1, 1'b1);
                    load_mem(width_word, 1'b0, a, 0);   // Memory unchanged
                end
            end
        end
    endtask

    task automatic mmio_access(input lsu_op_e op, input word_t addr, input word_t data);
        run_access(op, width_word, 1'b0, addr, data, 0);
        check_flag("mmio flag", got_mmio, 1'b1);
        check_flag("mmio error flag", got_err, 1'b0);
        check_flag("mmio ready in first cycle", got_lat == 1, 1'b1);
    endtask

    task automatic test_mmio;
        for (int i = 0; i < 4; i++) begin
            shadow_scr[i] = $urandom();
            mmio_access(op_store, `MMIO_BASE_ADDR + 4*i, shadow_scr[i]);
        end
        for (int i = 0; i < 4; i++) begin
            mmio_access(op_load, `MMIO_BASE_ADDR + 4*i, '0);
            check_word("scratch readback", got_rdata, shadow_scr[i]);
        end
        mmio_access(op_load, `MMIO_BASE_ADDR + 32'h10, '0);
        check_word("id register", got_rdata, `MMIO_ID);
        mmio_access(op_store, `MMIO_BASE_ADDR + 32'h10, $urandom());
        mmio_access(op_load, `MMIO_BASE_ADDR + 32'h10, '0);
        check_word("id after write", got_rdata, `MMIO_ID);
        mmio_access(op_load, `MMIO_BASE_ADDR + 32'h14, '0);
        check_word("unmapped offset", got_rdata, '0);
        for (int i = 0; i < 5; i++) begin
            load_mem(width_word, 1'b0, word_t'(4*i), 0);   // Low memory untouched
        end
    endtask

    task automatic test_stall;
        word_t      r;
        lsu_width_e w;
        rand_hold = 1'b1;
        for (int i = 0; i < 40; i++) begin
            r = $urandom();
            w = (r[1:0] == 2'd0) ? width_byte : (r[1:0] == 2'd1) ? width_half : width_word;
            if (r[2]) begin
                store_mem(w, rand_addr(w), $urandom(), int'(r[6:4]));
            end else begin
                load_mem(w, r[3], rand_addr(w), int'(r[6:4]));
            end
        end
        rand_hold = 1'b0;
    endtask

    initial begin
        g_resetn     = 1'b0;
        lsu_valid    = 1'b0;
        lsu_op       = op_load;
        lsu_width    = width_word;
        lsu_signed   = 1'b0;
        lsu_addr     = '0;
        lsu_wdata    = '0;
        pipe_prog    = 1'b0;
        hold_lsu_req = 1'b0;
        ext_hold     = 1'b0;
        void'($urandom(32298));                 // Fixed seed for the run
        repeat (8) @(posedge g_clk);
        #1;
        g_resetn = 1'b1;

        init_memory();
        test_word_rw();
        test_sub_word();
        test_misaligned();
        test_mmio();
        test_stall();

        $display("Checks: %0d, errors: %0d, accesses: %0d", n_checks, n_errors, n_access);
        if (n_errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: hdl/lsu_top.sv
/*
 * LSU subsystem top
 * Load/store unit, load aligner, data memory and MMIO registers
 */
`default_nettype none

module lsu_top (
    input  wire                 g_clk,          // Global clock
    input  wire                 g_resetn,       // Sync reset, active low
    input  wire                 lsu_valid,      // Instruction present
    input  lsu_pkg::lsu_op_e    lsu_op,         // Load or store
    input  lsu_pkg::lsu_width_e lsu_width,      // Access width
    input  wire                 lsu_signed,     // Sign extend loads
    input  bus_pkg::word_t      lsu_addr,       // Byte address
    input  bus_pkg::word_t      lsu_wdata,      // Store data
    input  wire                 pipe_prog,      // Instruction retires
    input  wire                 hold_lsu_req,   // Stall request in the unit
    input  wire                 ext_hold,       // Stall grant at the memory
    output logic                lsu_ready,      // Instruction complete
    output logic                lsu_a_error,    // Misaligned address
    output logic                lsu_mmio,       // MMIO access
    output bus_pkg::word_t      lsu_rdata       // Load result
);
    import bus_pkg::*;

    logic  mmio_en;
    logic  mmio_wen;
    word_t mmio_addr;
    word_t mmio_wdata;
    word_t mmio_rdata;

    dmem_if dmem_bus ();

    lsu_core i_lsu_core (
        .g_clk        (g_clk),
        .g_resetn     (g_resetn),
        .lsu_valid    (lsu_valid),
        .lsu_op       (lsu_op),
        .lsu_width    (lsu_width),
        .lsu_addr     (lsu_addr),
        .lsu_wdata    (lsu_wdata),
        .pipe_prog    (pipe_prog),
        .hold_lsu_req (hold_lsu_req),
        .lsu_ready    (lsu_ready),
        .lsu_a_error  (lsu_a_error),
        .lsu_mmio     (lsu_mmio),
        .mmio_en      (mmio_en),
        .mmio_wen     (mmio_wen),
        .mmio_addr    (mmio_addr),
        .mmio_wdata   (mmio_wdata),
        .dmem         (dmem_bus.lsu)
    );

    load_align i_load_align (
        .lsu_mmio     (lsu_mmio),
        .lsu_width    (lsu_width),
        .lsu_signed   (lsu_signed),
        .addr_lsb     (lsu_addr[1:0]),
        .dmem_rdata   (dmem_bus.rdata),
        .mmio_rdata   (mmio_rdata),
        .lsu_rdata    (lsu_rdata)
    );

    dmem_sram i_dmem_sram (
        .g_clk        (g_clk),
        .g_resetn     (g_resetn),
        .ext_hold     (ext_hold),
        .dmem         (dmem_bus.mem)
    );

    mmio_regs i_mmio_regs (
        .g_clk        (g_clk),
        .g_resetn     (g_resetn),
        .mmio_en      (mmio_en),
        .mmio_wen     (mmio_wen),
        .mmio_addr    (mmio_addr),
        .mmio_wdata   (mmio_wdata),
        .mmio_rdata   (mmio_rdata)
    );

endmodule

`default_nettype wire

// File: hdl/mmio_regs.sv
/*
 * MMIO register block
 * Four word-wide scratch registers and a read-only ID register
 */
`default_nettype none

`include "lsu_cfg.svh"

module mmio_regs (
    input  wire            g_clk,               // Global clock
    input  wire            g_resetn,            // Sync reset, active low
    input  wire            mmio_en,             // One-cycle access strobe
    input  wire            mmio_wen,            // Write access
    input  bus_pkg::word_t mmio_addr,           // Byte address in window
    input  bus_pkg::word_t mmio_wdata,          // Whole-word write data
    output bus_pkg::word_t mmio_rdata           // Read data, same cycle
);
    import bus_pkg::*;

    word_t     scratch [4];                     // Scratch registers
    mmio_reg_e reg_sel;

    assign reg_sel = mmio_reg_e'(mmio_addr[4:2]);

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            for (int i = 0; i < 4; i++) begin
                scratch[i] <= '0;
            end
        end else if (mmio_en && mmio_wen) begin
            case (reg_sel)
                scratch0: scratch[0] <= mmio_wdata;
                scratch1: scratch[1] <= mmio_wdata;
                scratch2: scratch[2] <= mmio_wdata;
                scratch3: scratch[3] <= mmio_wdata;
                default:  ;                     // ID and holes ignore writes
            endcase
        end
    end

    // Read mux ----------------------------
    always_comb begin
        case (reg_sel)
            scratch0: mmio_rdata = scratch[0];
            scratch1: mmio_rdata = scratch[1];
            scratch2: mmio_rdata = scratch[2];
            scratch3: mmio_rdata = scratch[3];
            id:       mmio_rdata = `MMIO_ID;
            default:  mmio_rdata = '0;          // Unmapped offset
        endcase
    end

endmodule

`default_nettype wire

// File: hdl/dmem_sram.sv
/*
 * Data memory
 * Byte-strobed synchronous word memory on the req/gnt bus,
 * read data one cycle after the grant
 */
`default_nettype none

`include "lsu_cfg.svh"

module dmem_sram (
    input  wire g_clk,                          // Global clock
    input  wire g_resetn,                       // Sync reset, active low
    input  wire ext_hold,                       // Another master owns the port
    dmem_if.mem dmem                            // Data memory bus
);
    import bus_pkg::*;

    localparam int IDX_W = $clog2(`DMEM_WORDS);

    word_t            mem [`DMEM_WORDS];        // Storage
    logic [IDX_W-1:0] idx;                      // Word index, wraps
    logic             acc;                      // Granted access

    assign idx      = dmem.addr[IDX_W+1:2];
    assign dmem.gnt = dmem.req && !ext_hold;
    assign acc      = dmem.gnt;

    // Write path --------------------------
    always_ff @(posedge g_clk) begin
        if (acc && dmem.wen) begin
            for (int b = 0; b < 4; b++) begin
                if (dmem.strb[b]) begin
                    mem[idx][8*b +: 8] <= dmem.wdata[8*b +: 8];
                end
            end
        end
    end

    // Read path ---------------------------
    always_ff @(posedge g_clk) begin
        if (acc && !dmem.wen) begin
            dmem.rdata <= mem[idx];             // Held until next read
        end
    end

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            dmem.rvalid <= 1'b0;
        end else begin
            dmem.rvalid <= acc && !dmem.wen;    // One cycle after grant
        end
    end

endmodule

`default_nettype wire

// File: lsu/lsu_core.sv
/*
 * Load/store unit
 * Checks alignment, routes MMIO accesses, drives the data memory bus
 * with lane-shifted store data and tracks completion until retirement
 */
`default_nettype none

`include "lsu_cfg.svh"

module lsu_core (
    input  wire                 g_clk,          // Global clock
    input  wire                 g_resetn,       // Sync reset, active low

    input  wire                 lsu_valid,      // Instruction present
    input  lsu_pkg::lsu_op_e    lsu_op,         // Load or store
    input  lsu_pkg::lsu_width_e lsu_width,      // Byte, half, word
    input  bus_pkg::word_t      lsu_addr,       // Byte address
    input  bus_pkg::word_t      lsu_wdata,      // Store data, low aligned
    input  wire                 pipe_prog,      // Instruction retires
    input  wire                 hold_lsu_req,   // Stall memory request

    output logic                lsu_ready,      // Instruction complete
    output logic                lsu_a_error,    // Misaligned address
    output logic                lsu_mmio,       // Access hits MMIO window

    output logic                mmio_en,        // One-cycle MMIO strobe
    output logic                mmio_wen,       // MMIO write
    output bus_pkg::word_t      mmio_addr,      // MMIO byte address
    output bus_pkg::word_t      mmio_wdata,     // MMIO write word

    dmem_if.lsu                 dmem            // Data memory bus
);
    import lsu_pkg::*;
    import bus_pkg::*;

    logic  mmio_done;                           // MMIO strobe already sent
    logic  load_pend;                           // Load granted, awaiting rvalid
    logic  finished;                            // Holds ready until pipe_prog
    logic  is_store;
    logic  dmem_gnt_now;                        // Handshake this cycle
    logic  txn_done;                            // Completion event
    strb_t lane_strb;
    word_t lane_data;

    assign is_store = (lsu_op == op_store);

    // Decode ------------------------------
    always_comb begin
        lsu_a_error = 1'b0;
        if (lsu_valid) begin
            if (lsu_width == width_half) begin
                lsu_a_error = lsu_addr[0];      // Half must be even
            end else if (lsu_width == width_word) begin
                lsu_a_error = |lsu_addr[1:0];   // Word on 4-byte boundary
            end
        end
    end

    assign lsu_mmio = lsu_valid &&
                      ((lsu_addr & `MMIO_BASE_MASK) == `MMIO_BASE_ADDR);

    // MMIO side ---------------------------
    assign mmio_en    = lsu_mmio && !mmio_done && !lsu_a_error;
    assign mmio_wen   = is_store;
    assign mmio_addr  = lsu_addr;
    assign mmio_wdata = lsu_wdata;              // Whole words only

    // Store lane placement ----------------
    always_comb begin
        case (lsu_width)
            width_byte: begin
                lane_strb = strb_t'(4'b0001 << lsu_addr[1:0]);
                lane_data = lsu_wdata << {lsu_addr[1:0], 3'b000};
            end
            width_half: begin
                lane_strb = strb_t'(4'b0011 << {lsu_addr[1], 1'b0});
                lane_data = lsu_wdata << {lsu_addr[1], 4'b0000};
            end
            width_word: begin
                lane_strb = 4'b1111;
                lane_data = lsu_wdata;
            end
            default: begin
                lane_strb = 4'b0000;            // Unused encoding, no lanes
                lane_data = '0;
            end
        endcase
    end

    // Memory request ----------------------
    assign dmem.req   = lsu_valid && !finished && !load_pend && !lsu_a_error &&
                        !hold_lsu_req && !lsu_mmio;
    assign dmem.wen   = is_store;
    assign dmem.strb  = lane_strb;
    assign dmem.addr  = {lsu_addr[`XLEN-1:2], 2'b00};
    assign dmem.wdata = lane_data;

    assign dmem_gnt_now = dmem.req && dmem.gnt;

    // Completion --------------------------
    assign txn_done = (dmem_gnt_now && is_store) ||  // Store done at grant
                      (load_pend && dmem.rvalid)  || // Load done at rvalid
                      mmio_en                     ||
                      lsu_a_error;

    assign lsu_ready = txn_done || finished;

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            mmio_done <= 1'b0;
            load_pend <= 1'b0;
            finished  <= 1'b0;
        end else begin
            mmio_done <= (mmio_done || mmio_en) && !pipe_prog;
            load_pend <= (load_pend || (dmem_gnt_now && !is_store)) &&
                         !dmem.rvalid && !pipe_prog;
            finished  <= (finished || txn_done) && !pipe_prog;
        end
    end

endmodule

`default_nettype wire

// File: lsu/load_align.sv
/*
 * Load data aligner
 * Selects the memory or MMIO word, moves the addressed lanes to bit 0
 * and sign- or zero-extends them
 */
`default_nettype none

`include "lsu_cfg.svh"

module load_align (
    input  wire                 lsu_mmio,       // Take MMIO read word
    input  lsu_pkg::lsu_width_e lsu_width,      // Access width
    input  wire                 lsu_signed,     // Sign extend result
    input  wire [1:0]           addr_lsb,       // Byte offset in word
    input  bus_pkg::word_t      dmem_rdata,     // Registered memory word
    input  bus_pkg::word_t      mmio_rdata,     // Combinational MMIO word
    output bus_pkg::word_t      lsu_rdata       // Aligned load result
);
    import lsu_pkg::*;
    import bus_pkg::*;

    word_t src_word;
    word_t shifted;
    logic  byte_msb;
    logic  half_msb;

    assign src_word = lsu_mmio ? mmio_rdata : dmem_rdata;
    assign shifted  = src_word >> {addr_lsb, 3'b000};   // Addressed lane to bit 0

    assign byte_msb = lsu_signed && shifted[7];
    assign half_msb = lsu_signed && shifted[15];

    always_comb begin
        case (lsu_width)
            width_byte: begin
                lsu_rdata = {{(`XLEN-8){byte_msb}}, shifted[7:0]};
            end
            width_half: begin
                lsu_rdata = {{(`XLEN-16){half_msb}}, shifted[15:0]};
            end
            width_word: begin
                lsu_rdata = src_word;           // Aligned, pass through
            end
            default: begin
                lsu_rdata = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: common/dmem_if.sv
/*
 * Data memory bus
 * req/gnt request channel and one-cycle-late read response
 */
`default_nettype none

interface dmem_if;
    import bus_pkg::*;

    logic  req;                             // Request, held until gnt
    logic  wen;                             // Write enable
    strb_t strb;                            // Byte lane strobe
    word_t addr;                            // Word aligned address
    word_t wdata;                           // Lane-shifted store data

    logic  gnt;                             // Request accepted this cycle
    logic  rvalid;                          // Read data valid, gnt + 1
    word_t rdata;                           // Read data, held until next read

    // Load/store unit side
    modport lsu (
        output req, wen, strb, addr, wdata,
        input  gnt, rvalid, rdata
    );

    // Memory side
    modport mem (
        input  req, wen, strb, addr, wdata,
        output gnt, rvalid, rdata
    );

endinterface

`default_nettype wire

// File: common/bus_pkg.sv
/*
 * Memory-side bus types
 * Data word, byte strobe and MMIO register index
 */
`default_nettype none

`include "lsu_cfg.svh"

package bus_pkg;

    typedef logic [`XLEN-1:0] word_t;       // Data or address word
    typedef logic [3:0]       strb_t;       // One bit per byte lane

    // MMIO register map, index is addr[4:2]
    typedef enum logic [2:0] {
        scratch0 = 3'd0,                    // Offset 0x00
        scratch1 = 3'd1,                    // Offset 0x04
        scratch2 = 3'd2,                    // Offset 0x08
        scratch3 = 3'd3,                    // Offset 0x0C
        id       = 3'd4                     // Offset 0x10, read only
    } mmio_reg_e;

endpackage

`default_nettype wire

// File: common/lsu_pkg.sv
/*
 * Instruction-side LSU types
 * Access width and operation as presented by the pipeline
 */
`default_nettype none

package lsu_pkg;

    // Access width --------------------------
    typedef enum logic [1:0] {
        width_byte = 2'b00,                 // 8-bit access
        width_half = 2'b01,                 // 16-bit, even address
        width_word = 2'b10                  // 32-bit, word aligned
    } lsu_width_e;

    // Operation -----------------------------
    typedef enum logic {
        op_load  = 1'b0,                    // Read from memory or MMIO
        op_store = 1'b1                     // Write to memory or MMIO
    } lsu_op_e;

endpackage

`default_nettype wire

// File: common/lsu_cfg.svh
/*
 * LSU subsystem configuration
 * Data width, MMIO window, data memory depth and the ID register value
 */
`ifndef LSU_CFG_SVH
`define LSU_CFG_SVH

// Data and address width
`define XLEN            32

// MMIO window, one 4 KiB page
`define MMIO_BASE_ADDR  32'h0000_1000
`define MMIO_BASE_MASK  32'hFFFF_F000

// Data memory depth in words
`define DMEM_WORDS      256

// Value returned by the read-only ID register
`define MMIO_ID         32'h4C53_5501

`endif
